// File: cpu_bus.f
source/bus_pkg.sv
source/axi_lane_align.sv
source/clint_timer.sv
source/bus_arbiter.sv
source/cpu_bus_top.sv
verif/tb_clock_gen.sv
verif/axi_mem_model.sv
verif/tb_cpu_bus.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cpu bus testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wall \
  -f cpu_bus.f \
  --top-module tb_cpu_bus \
  -o sim_cpu_bus

# keep going after the run so the log can be searched
./obj_dir/sim_cpu_bus > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0

// File: source/axi_lane_align.sv
module axi_lane_align (
  input  logic [bus_pkg::ADDR_W-1:0]     addr_i,
  input  logic [bus_pkg::SIZE_W-1:0]     size_i,
  input  logic [bus_pkg::DATA_W-1:0]     wdata_i,
  input  logic [bus_pkg::AXI_DATA_W-1:0] rdata64_i,
  output bus_pkg::axi_w_t                w_o,
  output logic [bus_pkg::DATA_W-1:0]     rdata_o
);

  localparam int HALF_STRB_W = bus_pkg::AXI_STRB_W / 2;

  logic [1:0]                 offset;
  logic [4:0]                 shamt;
  logic [HALF_STRB_W-1:0]     strb_base;
  logic [HALF_STRB_W-1:0]     strb_sh;
  logic [bus_pkg::DATA_W-1:0] wdata_sh;
  logic [bus_pkg::DATA_W-1:0] half;
  logic [bus_pkg::DATA_W-1:0] half_sh;
  logic [bus_pkg::DATA_W-1:0] size_mask;

  // byte offset inside the 32-bit word
  assign offset = addr_i[1:0];
  assign shamt  = {offset, 3'b000};

  // strobe and zero-extend mask per access size
  always_comb
  begin
    case (size_i)
      bus_pkg::SIZE_BYTE:
      begin
        strb_base = 4'b0001;
        size_mask = 32'h0000_00ff;
      end
      bus_pkg::SIZE_HALF:
      begin
        strb_base = 4'b0011;
        size_mask = 32'h0000_ffff;
      end
      default:
      begin
        strb_base = 4'b1111;
        size_mask = 32'hffff_ffff;
      end
    endcase
  end

  // write side
  assign strb_sh  = strb_base << offset;
  assign wdata_sh = wdata_i << shamt;

  // data goes out on both halves, strobes pick the live one
  assign w_o.data = {wdata_sh, wdata_sh};
  assign w_o.strb = addr_i[2] ? {strb_sh, {HALF_STRB_W{1'b0}}}
                              : {{HALF_STRB_W{1'b0}}, strb_sh};

  // read side
  // addr[2] picks the 32-bit half of the beat
  assign half = addr_i[2] ? rdata64_i[bus_pkg::AXI_DATA_W-1:bus_pkg::DATA_W]
                          : rdata64_i[bus_pkg::DATA_W-1:0];

  // drop lower bytes, then clear above the access size
  assign half_sh = half >> shamt;
  assign rdata_o = half_sh & size_mask;

endmodule

// File: source/bus_arbiter.sv
module bus_arbiter (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          ifu_req_i,
  input  logic [bus_pkg::ADDR_W-1:0]    ifu_addr_i,
  input  logic                          lsu_req_i,
  input  bus_pkg::bus_req_t             lsu_cmd_i,
  input  logic                          arready_i,
  input  bus_pkg::axi_r_t               r_i,
  input  logic                          rvalid_i,
  input  logic                          awready_i,
  input  logic                          wready_i,
  input  bus_pkg::axi_b_t               b_i,
  input  logic                          bvalid_i,
  input  bus_pkg::axi_w_t               lane_w_i,
  input  logic [bus_pkg::DATA_W-1:0]    lane_rdata_i,
  input  logic [bus_pkg::DATA_W-1:0]    clint_rdata_i,
  output bus_pkg::axi_ar_t              ar_o,
  output logic                          arvalid_o,
  output bus_pkg::axi_aw_t              aw_o,
  output logic                          awvalid_o,
  output bus_pkg::axi_w_t               w_o,
  output logic                          wvalid_o,
  output logic [bus_pkg::ADDR_W-1:0]    lane_addr_o,
  output logic [bus_pkg::SIZE_W-1:0]    lane_size_o,
  output logic [bus_pkg::DATA_W-1:0]    lane_wdata_o,
  output logic                          clint_rd_o,
  output logic                          clint_hi_o,
  output logic [bus_pkg::DATA_W-1:0]    ifu_rdata_o,
  output logic                          ifu_done_o,
  output logic [bus_pkg::DATA_W-1:0]    lsu_rdata_o,
  output logic                          lsu_done_o,
  output logic [7:0]                    console_byte_o,
  output logic                          console_valid_o
);

  bus_pkg::grant_e   state_q;
  bus_pkg::bus_req_t cmd_q;
  logic              ifu_want;
  logic              lsu_want;
  logic              lsu_clint;
  logic              lsu_serial;
  logic              idle;

  // client still holds its level on the cycle its done is out
  assign ifu_want = ifu_req_i & ~ifu_done_o;
  assign lsu_want = lsu_req_i & ~lsu_done_o;
  assign idle     = (state_q == bus_pkg::IDLE);

  // local targets, lsu only
  assign lsu_clint  = ~lsu_cmd_i.we &
                      ((lsu_cmd_i.addr == bus_pkg::MTIME_LO_ADDR) |
                       (lsu_cmd_i.addr == bus_pkg::MTIME_HI_ADDR));
  assign lsu_serial = lsu_cmd_i.we & (lsu_cmd_i.addr == bus_pkg::SERIAL_ADDR);

  // timer samples mtime on the same edge the request is granted
  assign clint_rd_o = idle & lsu_want & lsu_clint;
  assign clint_hi_o = (lsu_cmd_i.addr == bus_pkg::MTIME_HI_ADDR);

  // latched command feeds the aligner and both address channels
  assign lane_addr_o  = cmd_q.addr;
  assign lane_size_o  = cmd_q.size;
  assign lane_wdata_o = cmd_q.wdata;
  assign ar_o         = '{addr: cmd_q.addr, size: cmd_q.size};
  assign aw_o         = '{addr: cmd_q.addr, size: cmd_q.size};
  assign w_o          = lane_w_i;

  // grant fsm and channel valids
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q         <= bus_pkg::IDLE;
      arvalid_o       <= 1'b0;
      awvalid_o       <= 1'b0;
      wvalid_o        <= 1'b0;
      ifu_done_o      <= 1'b0;
      lsu_done_o      <= 1'b0;
      console_valid_o <= 1'b0;
    end
    else
    begin
      // pulses by default
      ifu_done_o      <= 1'b0;
      lsu_done_o      <= 1'b0;
      console_valid_o <= 1'b0;
      case (state_q)
        bus_pkg::IDLE:
        begin
          // lsu has priority
          if (lsu_want)
          begin
            if (lsu_clint)
            begin
              state_q <= bus_pkg::CLINT_RD;
            end
            else if (lsu_serial)
            begin
              state_q         <= bus_pkg::SERIAL_WR;
              console_valid_o <= 1'b1;
              lsu_done_o      <= 1'b1;
            end
            else if (lsu_cmd_i.we)
            begin
              state_q   <= bus_pkg::LSU_WR;
              awvalid_o <= 1'b1;
              wvalid_o  <= 1'b1;
            end
            else
            begin
              state_q   <= bus_pkg::LSU_RD;
              arvalid_o <= 1'b1;
            end
          end
          else if (ifu_want)
          begin
            state_q   <= bus_pkg::IFU_RD;
            arvalid_o <= 1'b1;
          end
        end
        bus_pkg::IFU_RD, bus_pkg::LSU_RD:
        begin
          if (arready_i)
          begin
            arvalid_o <= 1'b0;
          end
          // rready tied high, so rvalid is the beat
          if (rvalid_i)
          begin
            state_q    <= bus_pkg::IDLE;
            ifu_done_o <= (state_q == bus_pkg::IFU_RD);
            lsu_done_o <= (state_q == bus_pkg::LSU_RD);
          end
        end
        bus_pkg::LSU_WR:
        begin
          // aw and w retire on their own
          if (awready_i)
          begin
            awvalid_o <= 1'b0;
          end
          if (wready_i)
          begin
            wvalid_o <= 1'b0;
          end
          if (bvalid_i)
          begin
            state_q    <= bus_pkg::IDLE;
            lsu_done_o <= 1'b1;
          end
        end
        bus_pkg::CLINT_RD:
        begin
          // timer word is ready now
          state_q    <= bus_pkg::IDLE;
          lsu_done_o <= 1'b1;
        end
        default:
        begin
          state_q <= bus_pkg::IDLE;
        end
      endcase
    end
  end

  // command and response payloads
  always_ff @(posedge clk)
  begin
    if (idle && lsu_want)
    begin
      cmd_q          <= lsu_cmd_i;
      console_byte_o <= lsu_cmd_i.wdata[7:0];
    end
    else if (idle && ifu_want)
    begin
      // fetch is always a full word read
      cmd_q <= '{addr: ifu_addr_i, wdata: '0, size: bus_pkg::SIZE_WORD, we: 1'b0};
    end
    if (rvalid_i && state_q == bus_pkg::IFU_RD)
    begin
      ifu_rdata_o <= lane_rdata_i;
    end
    if (rvalid_i && state_q == bus_pkg::LSU_RD)
    begin
      lsu_rdata_o <= lane_rdata_i;
    end
    else if (state_q == bus_pkg::CLINT_RD)
    begin
      lsu_rdata_o <= clint_rdata_i;
    end
  end

  // slave never reports an error
  a_rresp_okay: assert property (@(posedge clk) disable iff (rst)
    rvalid_i |-> r_i.resp == bus_pkg::RESP_OKAY);
  a_bresp_okay: assert property (@(posedge clk) disable iff (rst)
    bvalid_i |-> b_i.resp == bus_pkg::RESP_OKAY);

  // one client served at a time
  a_one_done: assert property (@(posedge clk) disable iff (rst)
    !(ifu_done_o && lsu_done_o));

  // ar held steady until taken
  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o));

endmodule

// File: source/bus_pkg.sv
package bus_pkg;

  // bus widths
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int AXI_DATA_W = 64;
  localparam int AXI_STRB_W = 8;
  localparam int SIZE_W     = 3;
  localparam int MTIME_W    = 64;

  // clint mtime word addresses
  localparam logic [ADDR_W-1:0] MTIME_LO_ADDR = 32'h0200_BFF8;
  localparam logic [ADDR_W-1:0] MTIME_HI_ADDR = 32'h0200_BFFC;
  // console byte port, store only
  localparam logic [ADDR_W-1:0] SERIAL_ADDR   = 32'h1000_0000;

  // only legal axi response
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // axi size codes, shared by the clients
  localparam logic [SIZE_W-1:0] SIZE_BYTE = 3'd0;
  localparam logic [SIZE_W-1:0] SIZE_HALF = 3'd1;
  localparam logic [SIZE_W-1:0] SIZE_WORD = 3'd2;

  // one client request
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [SIZE_W-1:0] size;
    logic              we;
  } bus_req_t;

  // axi payloads, single beat, id 0
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [SIZE_W-1:0] size;
  } axi_ar_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [SIZE_W-1:0] size;
  } axi_aw_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;
  } axi_w_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [1:0]            resp;
  } axi_r_t;

  typedef struct packed {
    logic [1:0] resp;
  } axi_b_t;

  // who owns the bus right now
  typedef enum logic [2:0] {
    IDLE,
    IFU_RD,
    LSU_RD,
    LSU_WR,
    CLINT_RD,
    SERIAL_WR
  } grant_e;

endpackage

// File: source/clint_timer.sv
module clint_timer (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       rd_i,
  input  logic                       hi_i,
  output logic [bus_pkg::DATA_W-1:0] rdata_o
);

  logic [bus_pkg::MTIME_W-1:0] mtime_q;

  // free running mtime
  // zero during reset, counts every cycle after
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime_q <= '0;
    end
    else
    begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  // read port
  // word of the count at the read edge, valid next cycle
  // held until the next read
  always_ff @(posedge clk)
  begin
    if (rd_i)
    begin
      if (hi_i)
      begin
        rdata_o <= mtime_q[bus_pkg::MTIME_W-1:bus_pkg::DATA_W];
      end
      else
      begin
        rdata_o <= mtime_q[bus_pkg::DATA_W-1:0];
      end
    end
  end

endmodule

// File: source/cpu_bus_top.sv
module cpu_bus_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       ifu_req_i,
  input  logic [bus_pkg::ADDR_W-1:0] ifu_addr_i,
  input  logic                       lsu_req_i,
  input  bus_pkg::bus_req_t          lsu_cmd_i,
  input  logic                       arready_i,
  input  bus_pkg::axi_r_t            r_i,
  input  logic                       rvalid_i,
  input  logic                       awready_i,
  input  logic                       wready_i,
  input  bus_pkg::axi_b_t            b_i,
  input  logic                       bvalid_i,
  output logic [bus_pkg::DATA_W-1:0] ifu_rdata_o,
  output logic                       ifu_done_o,
  output logic [bus_pkg::DATA_W-1:0] lsu_rdata_o,
  output logic                       lsu_done_o,
  output logic [7:0]                 console_byte_o,
  output logic                       console_valid_o,
  output bus_pkg::axi_ar_t           ar_o,
  output logic                       arvalid_o,
  output logic                       rready_o,
  output bus_pkg::axi_aw_t           aw_o,
  output logic                       awvalid_o,
  output bus_pkg::axi_w_t            w_o,
  output logic                       wvalid_o,
  output logic                       bready_o
);

  logic [bus_pkg::ADDR_W-1:0] lane_addr;
  logic [bus_pkg::SIZE_W-1:0] lane_size;
  logic [bus_pkg::DATA_W-1:0] lane_wdata;
  logic [bus_pkg::DATA_W-1:0] lane_rdata;
  bus_pkg::axi_w_t            lane_w;
  logic                       clint_rd;
  logic                       clint_hi;
  logic [bus_pkg::DATA_W-1:0] clint_rdata;

  // single outstanding beat, responses always accepted
  assign rready_o = 1'b1;
  assign bready_o = 1'b1;

  // grant, decode and channel sequencing
  bus_arbiter u_arbiter (
    .clk             (clk),
    .rst             (rst),
    .ifu_req_i       (ifu_req_i),
    .ifu_addr_i      (ifu_addr_i),
    .lsu_req_i       (lsu_req_i),
    .lsu_cmd_i       (lsu_cmd_i),
    .arready_i       (arready_i),
    .r_i             (r_i),
    .rvalid_i        (rvalid_i),
    .awready_i       (awready_i),
    .wready_i        (wready_i),
    .b_i             (b_i),
    .bvalid_i        (bvalid_i),
    .lane_w_i        (lane_w),
    .lane_rdata_i    (lane_rdata),
    .clint_rdata_i   (clint_rdata),
    .ar_o            (ar_o),
    .arvalid_o       (arvalid_o),
    .aw_o            (aw_o),
    .awvalid_o       (awvalid_o),
    .w_o             (w_o),
    .wvalid_o        (wvalid_o),
    .lane_addr_o     (lane_addr),
    .lane_size_o     (lane_size),
    .lane_wdata_o    (lane_wdata),
    .clint_rd_o      (clint_rd),
    .clint_hi_o      (clint_hi),
    .ifu_rdata_o     (ifu_rdata_o),
    .ifu_done_o      (ifu_done_o),
    .lsu_rdata_o     (lsu_rdata_o),
    .lsu_done_o      (lsu_done_o),
    .console_byte_o  (console_byte_o),
    .console_valid_o (console_valid_o)
  );

  // 32/64 lane steering, read data straight off r
  axi_lane_align u_lane_align (
    .addr_i    (lane_addr),
    .size_i    (lane_size),
    .wdata_i   (lane_wdata),
    .rdata64_i (r_i.data),
    .w_o       (lane_w),
    .rdata_o   (lane_rdata)
  );

  // local mtime
  clint_timer u_clint (
    .clk     (clk),
    .rst     (rst),
    .rd_i    (clint_rd),
    .hi_i    (clint_hi),
    .rdata_o (clint_rdata)
  );

endmodule

// File: verif/axi_mem_model.sv
module axi_mem_model (
  input  logic             clk,
  input  logic             rst,
  input  bus_pkg::axi_ar_t ar_i,
  input  logic             arvalid_i,
  output logic             arready_o,
  output bus_pkg::axi_r_t  r_o,
  output logic             rvalid_o,
  input  bus_pkg::axi_aw_t aw_i,
  input  logic             awvalid_i,
  output logic             awready_o,
  input  bus_pkg::axi_w_t  w_i,
  input  logic             wvalid_i,
  output logic             wready_o,
  output bus_pkg::axi_b_t  b_o,
  output logic             bvalid_o
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [7:0]      mem [logic [31:0]];
  int              seed;
  int              rd_wait;
  int              wr_wait;
  logic            rd_busy;
  logic            aw_got;
  logic            w_got;
  logic [31:0]     rd_addr;
  logic [31:0]     wr_addr;
  bus_pkg::axi_w_t w_lat;

  // untouched bytes follow a pattern of the full address
  function automatic logic [7:0] fill_byte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
  endfunction

  function automatic logic [63:0] read_beat(input logic [31:0] a);
    logic [63:0] beat;
    logic [31:0] base;
    base = {a[31:3], 3'b000};
    for (int i = 0; i < 8; i++)
    begin
      beat[8*i +: 8] = mem.exists(base + i) ? mem[base + i] : fill_byte(base + i);
    end
    return beat;
  endfunction

  initial
  begin
    seed = 32'hdca0da59;
  end

  always @(posedge clk)
  begin
    if (rst)
    begin
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      r_o       <= '0;
      b_o       <= '0;
      rd_busy   <= 1'b0;
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
      rd_wait   <= 0;
      wr_wait   <= 0;
    end
    else
    begin
      rvalid_o <= 1'b0;
      bvalid_o <= 1'b0;
      // ar accept with random ready, then a random response delay
      if (arvalid_i && arready_o)
      begin
        arready_o <= 1'b0;
        rd_busy   <= 1'b1;
        rd_addr   <= ar_i.addr;
        rd_wait   <= $random(seed) & 3;
      end
      else if (arvalid_i && !rd_busy)
      begin
        arready_o <= $random(seed) & 1;
      end
      if (rd_busy)
      begin
        if (rd_wait == 0)
        begin
          rvalid_o   <= 1'b1;
          r_o.data   <= read_beat(rd_addr);
          r_o.resp   <= bus_pkg::RESP_OKAY;
          rd_busy    <= 1'b0;
        end
        else
        begin
          rd_wait <= rd_wait - 1;
        end
      end
      // aw and w taken independently
      if (awvalid_i && awready_o)
      begin
        awready_o <= 1'b0;
        aw_got    <= 1'b1;
        wr_addr   <= aw_i.addr;
      end
      else if (awvalid_i && !aw_got)
      begin
        awready_o <= $random(seed) & 1;
      end
      if (wvalid_i && wready_o)
      begin
        wready_o <= 1'b0;
        w_got    <= 1'b1;
        w_lat    <= w_i;
      end
      else if (wvalid_i && !w_got)
      begin
        wready_o <= $random(seed) & 1;
      end
      // both halves in, commit strobed bytes and answer on b
      if (aw_got && w_got)
      begin
        if (wr_wait == 0)
        begin
          for (int i = 0; i < 8; i++)
          begin
            if (w_lat.strb[i])
            begin
              mem[{wr_addr[31:3], 3'b000} + i] = w_lat.data[8*i +: 8];
            end
          end
          bvalid_o  <= 1'b1;
          b_o.resp  <= bus_pkg::RESP_OKAY;
          aw_got    <= 1'b0;
          w_got     <= 1'b0;
          wr_wait   <= $random(seed) & 3;
        end
        else
        begin
          wr_wait <= wr_wait - 1;
        end
      end
    end
  end

endmodule

// File: verif/tb_clock_gen.sv
module tb_clock_gen (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 100ps;

  // 4 ns period
  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // reset held for 8 rising edges
  initial
  begin
    rst = 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// File: verif/tb_cpu_bus.sv
module tb_cpu_bus;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_FETCH   = 40;
  localparam int N_LS      = 40;
  localparam int N_CONT    = 20;
  localparam int N_TIMER   = 12;
  localparam int N_CONSOLE = 12;
  localparam int N_OPS     = N_FETCH + 2 * N_LS + 2 * N_CONT + N_TIMER + N_CONSOLE + 10;

  logic clk;
  logic rst;
  logic ifu_req;
  logic [31:0] ifu_addr;
  logic lsu_req;
  bus_pkg::bus_req_t lsu_cmd;
  logic [31:0] ifu_rdata;
  logic ifu_done;
  logic [31:0] lsu_rdata;
  logic lsu_done;
  logic [7:0] console_byte;
  logic console_valid;
  bus_pkg::axi_ar_t ar;
  bus_pkg::axi_aw_t aw;
  bus_pkg::axi_w_t w;
  bus_pkg::axi_r_t r;
  bus_pkg::axi_b_t b;
  logic arvalid, arready, rvalid, rready;
  logic awvalid, awready, wvalid, wready, bvalid, bready;

  // reference model state
  logic [7:0]  shadow [logic [31:0]];
  logic [63:0] cyc;
  logic [7:0]  console_q[$];
  int          seed;
  int          errors;
  int          checks;
  int          ar_count, aw_count, ifu_dones, lsu_dones, ifu_reqs, lsu_reqs;
  logic [7:0]  last_strb;
  logic [63:0] last_wdata;

  tb_clock_gen u_clk (.clk(clk), .rst(rst));

  cpu_bus_top UUT (
    .clk(clk), .rst(rst),
    .ifu_req_i(ifu_req), .ifu_addr_i(ifu_addr),
    .lsu_req_i(lsu_req), .lsu_cmd_i(lsu_cmd),
    .arready_i(arready), .r_i(r), .rvalid_i(rvalid),
    .awready_i(awready), .wready_i(wready), .b_i(b), .bvalid_i(bvalid),
    .ifu_rdata_o(ifu_rdata), .ifu_done_o(ifu_done),
    .lsu_rdata_o(lsu_rdata), .lsu_done_o(lsu_done),
    .console_byte_o(console_byte), .console_valid_o(console_valid),
    .ar_o(ar), .arvalid_o(arvalid), .rready_o(rready),
    .aw_o(aw), .awvalid_o(awvalid), .w_o(w), .wvalid_o(wvalid), .bready_o(bready)
  );

  axi_mem_model u_mem (
    .clk(clk), .rst(rst),
    .ar_i(ar), .arvalid_i(arvalid), .arready_o(arready), .r_o(r), .rvalid_o(rvalid),
    .aw_i(aw), .awvalid_i(awvalid), .awready_o(awready),
    .w_i(w), .wvalid_i(wvalid), .wready_o(wready), .b_o(b), .bvalid_o(bvalid)
  );

  function automatic logic [7:0] fill_byte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
  endfunction

  // zero-extended little-endian read of the shadow memory
  function automatic logic [31:0] model_read(input logic [31:0] a, input int nb);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < nb; i++)
    begin
      v[8*i +: 8] = shadow.exists(a + i) ? shadow[a + i] : fill_byte(a + i);
    end
    return v;
  endfunction

  function automatic int rand_size();
    return $unsigned($random(seed)) % 3;
  endfunction

  // aligned address in a small window
  function automatic logic [31:0] rand_addr(input int nb);
    return ($random(seed) & 32'h3ff) & ~(nb - 1);
  endfunction

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
    checks++;
    assert (got === exp)
    else
    begin
      $display("[FAIL] %0t ns: %s expected %h got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond)
    else
    begin
      $display("error at %0t ns: %s", $time, what);
      errors++;
    end
  endtask

  task automatic ifu_op(input logic [31:0] a, output logic [31:0] data, output time t_done);
    @(posedge clk);
    ifu_req  <= 1'b1;
    ifu_addr <= a;
    ifu_reqs++;
    do
    begin
      @(posedge clk);
    end
    while (!ifu_done);
    ifu_req  <= 1'b0;
    data   = ifu_rdata;
    t_done = $time;
  endtask

  // edges counts rising edges from the raise to the one where done is seen
  task automatic lsu_op(input bus_pkg::bus_req_t cmd, output logic [31:0] data,
                        output int edges, output logic [63:0] cyc_at_sample,
                        output time t_done);
    @(posedge clk);
    lsu_req <= 1'b1;
    lsu_cmd <= cmd;
    lsu_reqs++;
    edges = 0;
    do
    begin
      @(posedge clk);
      edges++;
      // first edge is the sampling edge when the bus is idle
      if (edges == 1)
      begin
        cyc_at_sample = cyc;
      end
    end
    while (!lsu_done);
    lsu_req <= 1'b0;
    data   = lsu_rdata;
    t_done = $time;
  endtask

  // cycle count since reset, same rule as mtime
  always @(posedge clk)
  begin
    if (rst)
    begin
      cyc <= '0;
    end
    else
    begin
      cyc <= cyc + 64'd1;
    end
  end

  // bus monitor on the falling edge, where everything is settled
  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (arvalid && arready)
      begin
        ar_count++;
        // lsu wins, so a pending lsu request owns the read
        if (lsu_req)
        begin
          check_val("ar_o.addr", lsu_cmd.addr, ar.addr);
          check_val("ar_o.size", lsu_cmd.size, ar.size);
        end
        else
        begin
          check_val("ar_o.addr", ifu_addr, ar.addr);
          check_val("ar_o.size", bus_pkg::SIZE_WORD, ar.size);
        end
      end
      if (awvalid && awready)
      begin
        aw_count++;
        check_val("aw_o.addr", lsu_cmd.addr, aw.addr);
        check_val("aw_o.size", lsu_cmd.size, aw.size);
      end
      if (wvalid && wready)
      begin
        last_strb  = w.strb;
        last_wdata = w.data;
      end
      // responses always taken
      if (rvalid)
      begin
        check_val("rready_o", 1, rready);
      end
      if (bvalid)
      begin
        check_val("bready_o", 1, bready);
      end
      if (ifu_done)
      begin
        ifu_dones++;
      end
      if (lsu_done)
      begin
        lsu_dones++;
      end
      if (console_valid)
      begin
        if (console_q.size() == 0)
        begin
          check_true(1'b0, "console byte with nothing expected");
        end
        else
        begin
          check_val("console_byte_o", console_q.pop_front(), console_byte);
        end
      end
    end
  end

  // watchdog
  initial
  begin
    #(N_OPS * 40 * 4 + 100);
    $display("timeout: the tests did not finish in time");
    $display("Test failed");
    $finish;
  end

  initial
  begin
    bus_pkg::bus_req_t cmd;
    logic [31:0] a, a2, d, got, got2, exp;
    logic [63:0] c0;
    logic [7:0]  exp_strb;
    int nb, nb2, edges, e0, ar0, aw0;
    time t_i, t_l;

    seed = 32'hdca0da59;
    errors = 0;
    checks = 0;
    ifu_req = 1'b0;
    ifu_addr = '0;
    lsu_req = 1'b0;
    lsu_cmd = '0;

    // reset
    e0 = errors;
    @(posedge clk);
    while (rst)
    begin
      @(negedge clk);
      check_true(!arvalid && !awvalid && !wvalid, "axi valid high in reset");
      check_true(!ifu_done && !lsu_done && !console_valid, "pulse high in reset");
    end
    repeat (4)
    begin
      @(negedge clk);
      check_true(!arvalid && !awvalid && !wvalid && !console_valid, "activity after reset");
      check_true(!ifu_done && !lsu_done, "done pulse after reset");
    end
    check_val("ar handshakes", 0, ar_count);
    check_val("aw handshakes", 0, aw_count);
    $display("reset: %0d errors", errors - e0);

    // fetch reads from the preloaded pattern
    e0 = errors;
    for (int i = 0; i < N_FETCH; i++)
    begin
      a = rand_addr(4);
      ifu_op(a, got, t_i);
      check_val("ifu_rdata_o", model_read(a, 4), got);
    end
    check_val("ifu_done_o count", ifu_reqs, ifu_dones);
    $display("fetch reads: %0d ops, %0d errors", N_FETCH, errors - e0);

    // store, then a load that overlaps it
    e0 = errors;
    for (int i = 0; i < N_LS; i++)
    begin
      nb = 1 << rand_size();
      a  = rand_addr(nb);
      d  = $random(seed);
      cmd = '{addr: a, wdata: d, size: 3'($clog2(nb)), we: 1'b1};
      lsu_op(cmd, got, edges, c0, t_l);
      for (int j = 0; j < nb; j++)
      begin
        shadow[a + j] = d[8*j +: 8];
        check_val("w_o.data byte", d[8*j +: 8], last_wdata[8*(a[2:0] + j) +: 8]);
      end
      exp_strb = 8'((1 << nb) - 1) << a[2:0];
      check_val("w_o.strb", exp_strb, last_strb);
      nb2 = 1 << rand_size();
      a2  = a & ~(nb2 - 1);
      cmd = '{addr: a2, wdata: $random(seed), size: 3'($clog2(nb2)), we: 1'b0};
      lsu_op(cmd, got, edges, c0, t_l);
      check_val("lsu_rdata_o", model_read(a2, nb2), got);
    end
    $display("load/store round trip: %0d pairs, %0d errors", N_LS, errors - e0);

    // both clients raise on the same edge
    e0 = errors;
    for (int i = 0; i < N_CONT; i++)
    begin
      a   = rand_addr(4);
      nb  = 1 << rand_size();
      a2  = rand_addr(nb);
      cmd = '{addr: a2, wdata: '0, size: 3'($clog2(nb)), we: 1'b0};
      fork
        ifu_op(a, got, t_i);
        lsu_op(cmd, got2, edges, c0, t_l);
      join
      check_val("ifu_rdata_o", model_read(a, 4), got);
      check_val("lsu_rdata_o", model_read(a2, nb), got2);
      check_true(t_l < t_i, "fetch served before the load/store unit");
    end
    check_val("ifu_done_o count", ifu_reqs, ifu_dones);
    check_val("lsu_done_o count", lsu_reqs, lsu_dones);
    $display("contention: %0d pairs, %0d errors", N_CONT, errors - e0);

    // mtime words, no axi traffic
    e0 = errors;
    ar0 = ar_count;
    aw0 = aw_count;
    for (int i = 0; i < N_TIMER; i++)
    begin
      a = ($random(seed) & 1) ? bus_pkg::MTIME_HI_ADDR : bus_pkg::MTIME_LO_ADDR;
      cmd = '{addr: a, wdata: '0, size: bus_pkg::SIZE_WORD, we: 1'b0};
      lsu_op(cmd, got, edges, c0, t_l);
      check_val("timer done latency", 2, edges - 1);
      exp = (a == bus_pkg::MTIME_HI_ADDR) ? c0[63:32] : c0[31:0];
      check_val("lsu_rdata_o", exp, got);
    end
    check_val("ar handshakes", ar0, ar_count);
    $display("timer: %0d reads, %0d errors", N_TIMER, errors - e0);

    // console bytes
    e0 = errors;
    for (int i = 0; i < N_CONSOLE; i++)
    begin
      d = $random(seed);
      console_q.push_back(d[7:0]);
      cmd = '{addr: bus_pkg::SERIAL_ADDR, wdata: d, size: bus_pkg::SIZE_BYTE, we: 1'b1};
      lsu_op(cmd, got, edges, c0, t_l);
      check_val("console done latency", 1, edges - 1);
      check_val("console_valid_o", 1, console_valid);
    end
    repeat (2) @(posedge clk);
    check_val("aw handshakes", aw0, aw_count);
    check_true(console_q.size() == 0, "console byte missing");
    $display("console: %0d stores, %0d errors", N_CONSOLE, errors - e0);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("Test completed successfully");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
